// File: Bender.yml
package:
  name: pq_unit

sources:
  - files:
      - pq_cfg_pkg.sv
      - pq_ctrl_pkg.sv
      - pq_if.sv
      - value_router.sv
      - pq_engine.sv
      - pq_axil_front.sv
      - pq_result_collect.sv
      - pq_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_pq_top.sv

// File: pq_axil_front.sv
`timescale 1ns/1ps

module pq_axil_front (
   input  logic                         clk_i,
   input  logic                         arst_n_i,
   input  logic [pq_cfg_pkg::PQ_AW-1:0] awaddr_i,
   input  logic                         awvalid_i,
   output logic                         awready_o,
   input  logic [pq_cfg_pkg::PQ_DW-1:0] wdata_i,
   input  logic                         wvalid_i,
   output logic                         wready_o,
   output logic [1:0]                   bresp_o,
   output logic                         bvalid_o,
   input  logic                         bready_i,
   input  logic [pq_cfg_pkg::PQ_AW-1:0] araddr_i,
   input  logic                         arvalid_i,
   output logic                         arready_o,
   output logic [pq_cfg_pkg::PQ_DW-1:0] rdata_o,
   output logic [1:0]                   rresp_o,
   output logic                         rvalid_o,
   input  logic                         rready_i,
   input  logic [pq_cfg_pkg::PQ_NQ-1:0] busy_i,
   pq_cmd_if.front                      cmd [pq_cfg_pkg::PQ_NQ],
   pq_rd_if.front                       rd
);
   import pq_cfg_pkg::*;
   import pq_ctrl_pkg::*;

   logic             wr_hs;
   logic             wr_ok;
   logic [PQ_QW-1:0] wr_q;
   logic [PQ_OW-1:0] wr_off;
   pq_op_e           wr_op;
   logic             rd_hs;
   logic             rd_ok;
   logic [PQ_OW-1:0] rd_off;
   logic             bvalid_q;
   logic             rvalid_q;
   axi_resp_e        bresp_q;
   axi_resp_e        rresp_q;
   logic [PQ_DW-1:0] rdata_q;

   ////////////////////////////////////////////////////////////
   // Write channel
   ////////////////////////////////////////////////////////////
   // AW and W taken together, blocked by a pending B
   assign wr_hs     = awvalid_i && wvalid_i && !bvalid_q;
   assign awready_o = wr_hs;
   assign wready_o  = wr_hs;

   assign wr_q   = awaddr_i[PQ_AW-1 -: PQ_QW];
   assign wr_off = awaddr_i[PQ_OW-1:0];
   assign wr_op  = pq_op_e'(wdata_i[CMD_OP_LSB +: 2]);

   // Only a real opcode to an idle queue's CMD register is issued
   assign wr_ok = (wr_off == REG_CMD) && (wr_op == OP_ENQ || wr_op == OP_DEQ) && !busy_i[wr_q];

   for (genvar gi = 0; gi < PQ_NQ; gi++) begin : g_cmd
      assign cmd[gi].cmd_valid = wr_hs && wr_ok && (wr_q == gi);
      assign cmd[gi].cmd_op    = wr_op;
      assign cmd[gi].cmd_key   = wdata_i[CMD_KEY_LSB +: PQ_KW];
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         bvalid_q <= 1'b0;
         bresp_q  <= RESP_OKAY;
      end else if (wr_hs) begin
         bvalid_q <= 1'b1;
         bresp_q  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
      end else if (bready_i) begin
         bvalid_q <= 1'b0;
      end
   end

   assign bvalid_o = bvalid_q;
   assign bresp_o  = bresp_q;

   ////////////////////////////////////////////////////////////
   // Read channel
   ////////////////////////////////////////////////////////////
   assign rd_hs     = arvalid_i && !rvalid_q;
   assign arready_o = rd_hs;

   assign rd_off     = araddr_i[PQ_OW-1:0];
   assign rd.rd_q    = araddr_i[PQ_AW-1 -: PQ_QW];
   assign rd.rd_reg  = rd_off;
   assign rd.rd_take = rd_hs && (rd_off == REG_RESULT);
   // CMD and reserved offsets are not readable
   assign rd_ok = (rd_off == REG_STATUS) || (rd_off == REG_RESULT);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rvalid_q <= 1'b0;
         rresp_q  <= RESP_OKAY;
      end else if (rd_hs) begin
         rvalid_q <= 1'b1;
         rresp_q  <= rd_ok ? RESP_OKAY : RESP_SLVERR;
      end else if (rready_i) begin
         rvalid_q <= 1'b0;
      end
   end

   // Read word captured at the AR handshake
   always_ff @(posedge clk_i) begin
      if (rd_hs) rdata_q <= rd_ok ? rd.rd_data : '0;
   end

   assign rvalid_o = rvalid_q;
   assign rresp_o  = rresp_q;
   assign rdata_o  = rdata_q;

endmodule

// File: pq_cfg_pkg.sv
package pq_cfg_pkg;

   // Queue geometry
   localparam int PQ_NQ    = 4;
   localparam int PQ_DEPTH = 16;
   localparam int PQ_KW    = 8;
   localparam int PQ_IW    = 4;
   // Count reaches PQ_DEPTH, so one bit wider than the index
   localparam int PQ_CW    = 5;
   localparam int PQ_QW    = 2;

   // Bus geometry, queue select in the top address bits
   localparam int PQ_AW = 6;
   localparam int PQ_OW = 4;
   localparam int PQ_DW = 32;

   // Register offsets inside one queue window, 0xC reserved
   localparam logic [PQ_OW-1:0] REG_CMD    = 4'h0;
   localparam logic [PQ_OW-1:0] REG_STATUS = 4'h4;
   localparam logic [PQ_OW-1:0] REG_RESULT = 4'h8;

   // CMD word fields
   localparam int CMD_KEY_LSB = 0;
   localparam int CMD_OP_LSB  = 8;

endpackage

// File: pq_ctrl_pkg.sv
package pq_ctrl_pkg;

   // Command opcodes, as carried in CMD bits 9:8
   typedef enum logic [1:0] {
      OP_NONE = 2'd0,
      OP_ENQ  = 2'd1,
      OP_DEQ  = 2'd2
   } pq_op_e;

   // Value router modes
   typedef enum logic [2:0] {
      VR_IDLE,
      VR_ENQ_CMP,
      VR_ENQ_APPEND,
      VR_DEQ_TAKE,
      VR_DEQ_SHIFT
   } vr_mode_e;

   // Engine sequencer
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_ENQ_RD,
      ST_ENQ_CMP,
      ST_ENQ_END,
      ST_DEQ_RD,
      ST_DEQ_SHIFT,
      ST_DEQ_END
   } pq_state_e;

   // AXI response codes
   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10,
      RESP_DECERR = 2'b11
   } axi_resp_e;

endpackage

// File: pq_engine.sv
`timescale 1ns/1ps

module pq_engine (
   input  logic     clk_i,
   input  logic     arst_n_i,
   pq_cmd_if.engine cmd,
   pq_res_if.engine res
);
   import pq_cfg_pkg::*;
   import pq_ctrl_pkg::*;

   // Key RAM, one-cycle read
   logic [PQ_KW-1:0] mem [PQ_DEPTH];
   logic [PQ_KW-1:0] ram_q;
   logic [PQ_IW-1:0] rd_addr;
   logic [PQ_IW-1:0] wr_addr;
   logic             wr_en;
   // Holding register and router outputs
   logic [PQ_KW-1:0] hold_q;
   logic [PQ_KW-1:0] vr_ram_key;
   logic [PQ_KW-1:0] vr_hold_next;
   logic             vr_swap;
   logic             vr_take;
   vr_mode_e         mode;
   // Sequencer
   pq_state_e        state_q;
   logic [PQ_IW-1:0] idx_q;
   logic [PQ_IW-1:0] last_q;
   logic [PQ_CW-1:0] count_q;
   logic             ovf_q;
   logic             unf_q;
   logic             accept;
   logic             is_empty;
   logic             is_full;

   assign accept   = cmd.cmd_valid && (state_q == ST_IDLE);
   assign is_empty = (count_q == '0);
   assign is_full  = (count_q == PQ_CW'(PQ_DEPTH));

   ////////////////////////////////////////////////////////////
   // Sequencer
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= ST_IDLE;
         idx_q   <= '0;
         last_q  <= '0;
         count_q <= '0;
         ovf_q   <= 1'b0;
         unf_q   <= 1'b0;
      end else begin
         ovf_q <= 1'b0;
         unf_q <= 1'b0;
         case (state_q)
            ST_IDLE: begin
               idx_q <= '0;
               // Errors stay in idle, contents untouched
               if (accept && cmd.cmd_op == OP_ENQ) begin
                  if (is_full) ovf_q <= 1'b1;
                  else if (is_empty) state_q <= ST_ENQ_END;
                  else state_q <= ST_ENQ_RD;
               end else if (accept && cmd.cmd_op == OP_DEQ) begin
                  if (is_empty) unf_q <= 1'b1;
                  else state_q <= ST_DEQ_RD;
               end
            end
            ST_ENQ_RD: state_q <= ST_ENQ_CMP;
            // Walk to the last stored entry
            ST_ENQ_CMP: begin
               if (idx_q == last_q) state_q <= ST_ENQ_END;
               else idx_q <= idx_q + 1'b1;
            end
            ST_ENQ_END: begin
               last_q  <= count_q[PQ_IW-1:0];
               count_q <= count_q + 1'b1;
               state_q <= ST_IDLE;
            end
            // Single entry, nothing to shift
            ST_DEQ_RD: state_q <= (last_q == '0) ? ST_DEQ_END : ST_DEQ_SHIFT;
            ST_DEQ_SHIFT: begin
               if (idx_q + 1'b1 == last_q) state_q <= ST_DEQ_END;
               else idx_q <= idx_q + 1'b1;
            end
            ST_DEQ_END: begin
               last_q  <= last_q - 1'b1;
               count_q <= count_q - 1'b1;
               state_q <= ST_IDLE;
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Read one entry ahead of the compare or shift
   always_comb begin
      case (state_q)
         ST_ENQ_RD:             rd_addr = idx_q;
         ST_ENQ_CMP, ST_DEQ_RD: rd_addr = idx_q + 1'b1;
         ST_DEQ_SHIFT:          rd_addr = idx_q + PQ_IW'(2);
         // Idle pre-reads the head for a dequeue
         default:               rd_addr = '0;
      endcase
   end

   // Router mode and RAM write per state
   always_comb begin
      mode    = VR_IDLE;
      wr_en   = 1'b0;
      wr_addr = idx_q;
      case (state_q)
         ST_ENQ_CMP: begin
            mode  = VR_ENQ_CMP;
            wr_en = vr_swap;
         end
         ST_ENQ_END: begin
            mode    = VR_ENQ_APPEND;
            wr_en   = 1'b1;
            wr_addr = count_q[PQ_IW-1:0];
         end
         ST_DEQ_RD: mode = VR_DEQ_TAKE;
         ST_DEQ_SHIFT: begin
            mode  = VR_DEQ_SHIFT;
            wr_en = 1'b1;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (wr_en) mem[wr_addr] <= vr_ram_key;
      ram_q <= mem[rd_addr];
   end

   // New key on enqueue, then whatever the router hands back
   always_ff @(posedge clk_i) begin
      if (accept) hold_q <= cmd.cmd_key;
      else if (vr_swap || vr_take) hold_q <= vr_hold_next;
   end

   value_router u_router (
      .mode_i       (mode),
      .ram_key_i    (ram_q),
      .hold_key_i   (hold_q),
      .ram_wr_key_o (vr_ram_key),
      .hold_next_o  (vr_hold_next),
      .swap_o       (vr_swap),
      .take_o       (vr_take)
   );

   // Error cycle counts as busy so the collector sees a new command
   assign cmd.busy      = (state_q != ST_IDLE) || ovf_q || unf_q;
   assign res.res_valid = (state_q == ST_DEQ_END);
   assign res.res_key   = hold_q;
   assign res.count     = count_q;
   assign res.empty     = is_empty;
   assign res.full      = is_full;
   assign res.ovf_pulse = ovf_q;
   assign res.unf_pulse = unf_q;

endmodule

// File: pq_if.sv
`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// Command path, front end to one engine
////////////////////////////////////////////////////////////
interface pq_cmd_if;
   import pq_cfg_pkg::*;

   // One-cycle command strobe
   logic             cmd_valid;
   logic [1:0]       cmd_op;
   logic [PQ_KW-1:0] cmd_key;
   // High from the cycle after accept until done
   logic             busy;

   modport front (output cmd_valid, cmd_op, cmd_key);
   modport engine (input cmd_valid, cmd_op, cmd_key, output busy);
endinterface

////////////////////////////////////////////////////////////
// Result and status path, one engine to the collector
////////////////////////////////////////////////////////////
interface pq_res_if;
   import pq_cfg_pkg::*;

   logic             res_valid;
   logic [PQ_KW-1:0] res_key;
   logic [PQ_CW-1:0] count;
   logic             empty;
   logic             full;
   // Error strobes, made sticky in the collector
   logic             ovf_pulse;
   logic             unf_pulse;

   modport engine (output res_valid, res_key, count, empty, full, ovf_pulse, unf_pulse);
   modport collect (input res_valid, res_key, count, empty, full, ovf_pulse, unf_pulse);
endinterface

////////////////////////////////////////////////////////////
// Read selection, front end to collector
////////////////////////////////////////////////////////////
interface pq_rd_if;
   import pq_cfg_pkg::*;

   logic [PQ_QW-1:0] rd_q;
   logic [PQ_OW-1:0] rd_reg;
   // Accepted read of REG_RESULT
   logic             rd_take;
   // Combinational, same cycle as the selection
   logic [PQ_DW-1:0] rd_data;

   modport front (output rd_q, rd_reg, rd_take, input rd_data);
   modport collect (input rd_q, rd_reg, rd_take, output rd_data);
endinterface

// File: pq_result_collect.sv
`timescale 1ns/1ps

module pq_result_collect (
   input  logic                         clk_i,
   input  logic                         arst_n_i,
   pq_res_if.collect                    res [pq_cfg_pkg::PQ_NQ],
   input  logic [pq_cfg_pkg::PQ_NQ-1:0] busy_i,
   pq_rd_if.collect                     rd
);
   import pq_cfg_pkg::*;

   // Per-queue taps from the result buses
   logic [PQ_NQ-1:0] res_vld;
   logic [PQ_NQ-1:0] ovf_p;
   logic [PQ_NQ-1:0] unf_p;
   logic [PQ_NQ-1:0] empty_a;
   logic [PQ_NQ-1:0] full_a;
   logic [PQ_KW-1:0] res_key [PQ_NQ];
   logic [PQ_CW-1:0] cnt_a [PQ_NQ];
   // Held state
   logic [PQ_NQ-1:0] busy_prev;
   logic [PQ_NQ-1:0] vld_q;
   logic [PQ_NQ-1:0] ovf_q;
   logic [PQ_NQ-1:0] unf_q;
   logic [PQ_KW-1:0] key_q [PQ_NQ];
   // Clear sources
   logic [PQ_NQ-1:0] new_cmd;
   logic [PQ_NQ-1:0] take_sel;
   logic [PQ_DW-1:0] rd_word;

   for (genvar gi = 0; gi < PQ_NQ; gi++) begin : g_tap
      assign res_vld[gi] = res[gi].res_valid;
      assign res_key[gi] = res[gi].res_key;
      assign ovf_p[gi]   = res[gi].ovf_pulse;
      assign unf_p[gi]   = res[gi].unf_pulse;
      assign empty_a[gi] = res[gi].empty;
      assign full_a[gi]  = res[gi].full;
      assign cnt_a[gi]   = res[gi].count;
   end

   // Rising busy marks a freshly accepted command
   assign new_cmd  = busy_i & ~busy_prev;
   assign take_sel = rd.rd_take ? (PQ_NQ'(1) << rd.rd_q) : '0;

   // A pulse in the clear cycle still sets the bit
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_prev <= '0;
         vld_q     <= '0;
         ovf_q     <= '0;
         unf_q     <= '0;
      end else begin
         busy_prev <= busy_i;
         vld_q     <= (vld_q & ~new_cmd & ~take_sel) | res_vld;
         ovf_q     <= (ovf_q & ~new_cmd) | ovf_p;
         unf_q     <= (unf_q & ~new_cmd) | unf_p;
      end
   end

   always_ff @(posedge clk_i) begin
      for (int q = 0; q < PQ_NQ; q++) begin
         if (res_vld[q]) key_q[q] <= res_key[q];
      end
   end

   ////////////////////////////////////////////////////////////
   // Read word for the selected queue
   ////////////////////////////////////////////////////////////
   always_comb begin
      rd_word = '0;
      case (rd.rd_reg)
         REG_STATUS: begin
            rd_word[0]    = busy_i[rd.rd_q];
            rd_word[1]    = empty_a[rd.rd_q];
            rd_word[2]    = full_a[rd.rd_q];
            rd_word[3]    = ovf_q[rd.rd_q];
            rd_word[4]    = unf_q[rd.rd_q];
            rd_word[12:8] = cnt_a[rd.rd_q];
         end
         REG_RESULT: begin
            rd_word[8]   = vld_q[rd.rd_q];
            rd_word[7:0] = key_q[rd.rd_q];
         end
         default: ;
      endcase
   end

   assign rd.rd_data = rd_word;

endmodule

// File: pq_top.sv
`timescale 1ns/1ps

module pq_top (
   input  logic                         clk_i,
   input  logic                         arst_n_i,
   input  logic [pq_cfg_pkg::PQ_AW-1:0] awaddr_i,
   input  logic                         awvalid_i,
   output logic                         awready_o,
   input  logic [pq_cfg_pkg::PQ_DW-1:0] wdata_i,
   input  logic                         wvalid_i,
   output logic                         wready_o,
   output logic [1:0]                   bresp_o,
   output logic                         bvalid_o,
   input  logic                         bready_i,
   input  logic [pq_cfg_pkg::PQ_AW-1:0] araddr_i,
   input  logic                         arvalid_i,
   output logic                         arready_o,
   output logic [pq_cfg_pkg::PQ_DW-1:0] rdata_o,
   output logic [1:0]                   rresp_o,
   output logic                         rvalid_o,
   input  logic                         rready_i
);
   import pq_cfg_pkg::*;

   logic [PQ_NQ-1:0] busy_vec;

   pq_cmd_if cmd_bus [PQ_NQ] ();
   pq_res_if res_bus [PQ_NQ] ();
   pq_rd_if  rd_bus ();

   // One engine per queue, busy gathered into a vector
   for (genvar gi = 0; gi < PQ_NQ; gi++) begin : g_q
      pq_engine u_engine (
         .clk_i    (clk_i),
         .arst_n_i (arst_n_i),
         .cmd      (cmd_bus[gi]),
         .res      (res_bus[gi])
      );
      assign busy_vec[gi] = cmd_bus[gi].busy;
   end

   pq_axil_front u_front (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .awaddr_i  (awaddr_i),
      .awvalid_i (awvalid_i),
      .awready_o (awready_o),
      .wdata_i   (wdata_i),
      .wvalid_i  (wvalid_i),
      .wready_o  (wready_o),
      .bresp_o   (bresp_o),
      .bvalid_o  (bvalid_o),
      .bready_i  (bready_i),
      .araddr_i  (araddr_i),
      .arvalid_i (arvalid_i),
      .arready_o (arready_o),
      .rdata_o   (rdata_o),
      .rresp_o   (rresp_o),
      .rvalid_o  (rvalid_o),
      .rready_i  (rready_i),
      .busy_i    (busy_vec),
      .cmd       (cmd_bus),
      .rd        (rd_bus)
   );

   pq_result_collect u_collect (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .res      (res_bus),
      .busy_i   (busy_vec),
      .rd       (rd_bus)
   );

endmodule

// File: pq_trace.txt
# kind queue reg data resp exp | kind W write, R read, P poll STATUS until not busy
# reg, data and exp in hex, resp 0 OKAY 2 SLVERR, exp is the read word or final status
# reset state of every queue
R 0 4 00000000 0 00000002
R 1 4 00000000 0 00000002
R 2 4 00000000 0 00000002
R 3 4 00000000 0 00000002
R 0 8 00000000 0 00000000
R 1 8 00000000 0 00000000
R 2 8 00000000 0 00000000
R 3 8 00000000 0 00000000
# fill queue 1 with sixteen keys in scrambled order
W 1 0 0000015a 0 00000000
P 1 4 00000000 0 00000100
W 1 0 00000113 0 00000000
P 1 4 00000000 0 00000200
W 1 0 000001c7 0 00000000
P 1 4 00000000 0 00000300
W 1 0 00000180 0 00000000
P 1 4 00000000 0 00000400
W 1 0 00000102 0 00000000
P 1 4 00000000 0 00000500
W 1 0 000001ff 0 00000000
P 1 4 00000000 0 00000600
W 1 0 0000013c 0 00000000
P 1 4 00000000 0 00000700
W 1 0 00000191 0 00000000
P 1 4 00000000 0 00000800
W 1 0 00000127 0 00000000
P 1 4 00000000 0 00000900
W 1 0 0000016e 0 00000000
P 1 4 00000000 0 00000a00
W 1 0 000001b4 0 00000000
P 1 4 00000000 0 00000b00
W 1 0 00000108 0 00000000
P 1 4 00000000 0 00000c00
W 1 0 000001d9 0 00000000
P 1 4 00000000 0 00000d00
W 1 0 0000014f 0 00000000
P 1 4 00000000 0 00000e00
W 1 0 00000171 0 00000000
P 1 4 00000000 0 00000f00
W 1 0 000001a0 0 00000000
P 1 4 00000000 0 00001004
# seventeenth key is dropped with overflow
W 1 0 00000100 0 00000000
P 1 4 00000000 0 0000100c
# dequeue clears overflow, a write during it is refused
W 1 0 00000200 0 00000000
W 1 0 00000110 2 00000000
P 1 4 00000000 0 00000f00
R 1 8 00000000 0 00000102
R 1 8 00000000 0 00000000
W 1 0 00000200 0 00000000
P 1 4 00000000 0 00000e00
R 1 8 00000000 0 00000108
W 1 0 00000200 0 00000000
P 1 4 00000000 0 00000d00
R 1 8 00000000 0 00000113
# interleaved queues 2 and 3
W 2 0 00000140 0 00000000
W 3 0 00000190 0 00000000
W 2 0 00000120 0 00000000
W 3 0 00000130 0 00000000
P 2 4 00000000 0 00000200
P 3 4 00000000 0 00000200
W 2 0 00000200 0 00000000
P 2 4 00000000 0 00000100
R 2 8 00000000 0 00000120
W 3 0 00000200 0 00000000
P 3 4 00000000 0 00000100
R 3 8 00000000 0 00000130
P 1 4 00000000 0 00000d00
# underflow on queue 0, cleared by the next command
W 0 0 00000200 0 00000000
P 0 4 00000000 0 00000012
R 0 8 00000000 0 00000000
W 0 0 00000177 0 00000000
P 0 4 00000000 0 00000100
# refused writes and reads
W 0 0 00000055 2 00000000
W 0 4 00000105 2 00000000
P 0 4 00000000 0 00000100
R 0 c 00000000 2 00000000
R 0 0 00000000 2 00000000

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk_o,
   output logic arst_n_o
);
   localparam int HALF_PERIOD = 20;
   localparam int RST_CYCLES  = 4;

   // Free-running 40 ns clock
   initial begin
      clk_o = 1'b0;
      forever #(HALF_PERIOD) clk_o = ~clk_o;
   end

   // Reset released just after the fourth rising edge
   initial begin
      arst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      #2 arst_n_o = 1'b1;
   end

endmodule

// File: tb_pq_top.sv
`timescale 1ns/1ps

module tb_pq_top;
   import pq_cfg_pkg::*;
   import pq_ctrl_pkg::*;

   localparam int          DRV_DLY    = 2;
   localparam int          CYC_PER_OP = 200;
   localparam logic [31:0] SEED       = 32'hf6e3_36db;

   // One parsed trace line
   typedef struct packed {
      logic [7:0]       kind;
      logic [PQ_QW-1:0] q;
      logic [PQ_OW-1:0] off;
      logic [PQ_DW-1:0] data;
      logic [1:0]       resp;
      logic [PQ_DW-1:0] exp;
   } trace_op_t;

   logic             clk;
   logic             arst_n;
   logic [PQ_AW-1:0] awaddr;
   logic             awvalid;
   logic             awready;
   logic [PQ_DW-1:0] wdata;
   logic             wvalid;
   logic             wready;
   logic [1:0]       bresp;
   logic             bvalid;
   logic             bready;
   logic [PQ_AW-1:0] araddr;
   logic             arvalid;
   logic             arready;
   logic [PQ_DW-1:0] rdata;
   logic [1:0]       rresp;
   logic             rvalid;
   logic             rready;

   trace_op_t ops [$];
   int        n_ops   = 0;
   int        err_cnt = 0;

   tb_clk_gen u_clk_gen (
      .clk_o    (clk),
      .arst_n_o (arst_n)
   );

   pq_top UUT (
      .clk_i     (clk),
      .arst_n_i  (arst_n),
      .awaddr_i  (awaddr),
      .awvalid_i (awvalid),
      .awready_o (awready),
      .wdata_i   (wdata),
      .wvalid_i  (wvalid),
      .wready_o  (wready),
      .bresp_o   (bresp),
      .bvalid_o  (bvalid),
      .bready_i  (bready),
      .araddr_i  (araddr),
      .arvalid_i (arvalid),
      .arready_o (arready),
      .rdata_o   (rdata),
      .rresp_o   (rresp),
      .rvalid_o  (rvalid),
      .rready_i  (rready)
   );

   ////////////////////////////////////////////////////////////
   // Run control and compare tasks
   ////////////////////////////////////////////////////////////
   task automatic abort_run();
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic check_resp(input string name, input axi_resp_e got, input axi_resp_e exp);
      if (got !== exp) begin
         err_cnt++;
         $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_field(input string name, input logic [PQ_CW-1:0] got,
                              input logic [PQ_CW-1:0] exp);
      if (got !== exp) begin
         err_cnt++;
         $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_key(input string name, input logic [PQ_KW-1:0] got,
                            input logic [PQ_KW-1:0] exp);
      if (got !== exp) begin
         err_cnt++;
         $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   // Status word split into its fields
   task automatic check_status(input logic [PQ_DW-1:0] got, input logic [PQ_DW-1:0] exp);
      check_field("status.busy", got[0], exp[0]);
      check_field("status.empty", got[1], exp[1]);
      check_field("status.full", got[2], exp[2]);
      check_field("status.overflow", got[3], exp[3]);
      check_field("status.underflow", got[4], exp[4]);
      check_field("status.count", got[12:8], exp[12:8]);
   endtask

   // Key only meaningful while valid
   task automatic check_result(input logic [PQ_DW-1:0] got, input logic [PQ_DW-1:0] exp);
      check_field("result.valid", got[8], exp[8]);
      if (exp[8]) check_key("result.key", got[7:0], exp[7:0]);
   endtask

   task automatic check_rdata(input logic [PQ_DW-1:0] got, input logic [PQ_DW-1:0] exp);
      if (got !== exp) begin
         err_cnt++;
         $display("Error at %0t: rdata_o is %h, expected %h", $time, got, exp);
         abort_run();
      end
   endtask

   ////////////////////////////////////////////////////////////
   // AXI4-Lite master
   ////////////////////////////////////////////////////////////
   // Inputs change a little after the rising edge
   task automatic to_drive_point();
      @(posedge clk);
      #(DRV_DLY);
   endtask

   // Zero to three idle cycles before accepting a response
   task automatic random_stall();
      repeat ($urandom % 4) to_drive_point();
   endtask

   task automatic axi_write(input logic [PQ_AW-1:0] addr, input logic [PQ_DW-1:0] data,
                            output axi_resp_e resp);
      to_drive_point();
      awaddr  = addr;
      awvalid = 1'b1;
      wdata   = data;
      wvalid  = 1'b1;
      // Ready settles well before the falling edge
      @(negedge clk);
      while (!(awready && wready)) @(negedge clk);
      to_drive_point();
      awvalid = 1'b0;
      wvalid  = 1'b0;
      random_stall();
      bready = 1'b1;
      @(negedge clk);
      while (!bvalid) @(negedge clk);
      resp = axi_resp_e'(bresp);
      to_drive_point();
      bready = 1'b0;
   endtask

   task automatic axi_read(input logic [PQ_AW-1:0] addr, output axi_resp_e resp,
                           output logic [PQ_DW-1:0] data);
      to_drive_point();
      araddr  = addr;
      arvalid = 1'b1;
      @(negedge clk);
      while (!arready) @(negedge clk);
      to_drive_point();
      arvalid = 1'b0;
      random_stall();
      rready = 1'b1;
      @(negedge clk);
      while (!rvalid) @(negedge clk);
      resp = axi_resp_e'(rresp);
      data = rdata;
      to_drive_point();
      rready = 1'b0;
   endtask

   // Status reads until busy drops, watchdog bounds the loop
   task automatic poll_idle(input logic [PQ_AW-1:0] addr, output axi_resp_e resp,
                            output logic [PQ_DW-1:0] data);
      do begin
         axi_read(addr, resp, data);
      end while (data[0] !== 1'b0);
   endtask

   ////////////////////////////////////////////////////////////
   // Trace handling
   ////////////////////////////////////////////////////////////
   task automatic load_trace();
      int          fd;
      int          n;
      int          q_v;
      int          resp_v;
      logic [7:0]  kind_v;
      logic [31:0] off_v;
      logic [31:0] data_v;
      logic [31:0] exp_v;
      string       line;
      trace_op_t   op;
      fd = $fopen("pq_trace.txt", "r");
      if (fd == 0) begin
         $display("Could not open the trace file pq_trace.txt");
         abort_run();
      end else begin
         while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) != 0) begin
               // Comment and blank lines do not give six fields
               n = $sscanf(line, "%c %d %h %h %d %h", kind_v, q_v, off_v, data_v,
                           resp_v, exp_v);
               if (n == 6) begin
                  op.kind = kind_v;
                  op.q    = q_v[PQ_QW-1:0];
                  op.off  = off_v[PQ_OW-1:0];
                  op.data = data_v;
                  op.resp = resp_v[1:0];
                  op.exp  = exp_v;
                  ops.push_back(op);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic run_op(input trace_op_t op);
      logic [PQ_AW-1:0] addr;
      axi_resp_e        resp;
      logic [PQ_DW-1:0] data;
      addr = {op.q, op.off};
      case (op.kind)
         "W": begin
            axi_write(addr, op.data, resp);
            check_resp("bresp_o", resp, axi_resp_e'(op.resp));
         end
         "R": begin
            axi_read(addr, resp, data);
            check_resp("rresp_o", resp, axi_resp_e'(op.resp));
            if (op.off == REG_STATUS) check_status(data, op.exp);
            else if (op.off == REG_RESULT) check_result(data, op.exp);
            else check_rdata(data, op.exp);
         end
         "P": begin
            poll_idle(addr, resp, data);
            check_resp("rresp_o", resp, axi_resp_e'(op.resp));
            check_status(data, op.exp);
         end
         default: begin
            $display("Unknown operation kind in the trace file");
            abort_run();
         end
      endcase
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence and watchdog
   ////////////////////////////////////////////////////////////
   initial begin : main
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      void'($urandom(SEED));
      load_trace();
      if (ops.size() == 0) begin
         $display("The trace file holds no operations");
         abort_run();
      end else begin
         n_ops = ops.size();
         wait (arst_n === 1'b1);
         to_drive_point();
         to_drive_point();
         foreach (ops[i]) run_op(ops[i]);
         if (err_cnt == 0) begin
            $display("Finished with no errors");
            $finish;
         end else begin
            abort_run();
         end
      end
   end

   // Budget grows with the number of trace lines
   initial begin : watchdog
      wait (n_ops > 0);
      repeat (n_ops * CYC_PER_OP) @(posedge clk);
      $display("Watchdog expired, the run hung waiting on the DUT");
      abort_run();
   end

endmodule

// File: value_router.sv
`timescale 1ns/1ps

module value_router (
   input  pq_ctrl_pkg::vr_mode_e        mode_i,
   input  logic [pq_cfg_pkg::PQ_KW-1:0] ram_key_i,
   input  logic [pq_cfg_pkg::PQ_KW-1:0] hold_key_i,
   output logic [pq_cfg_pkg::PQ_KW-1:0] ram_wr_key_o,
   output logic [pq_cfg_pkg::PQ_KW-1:0] hold_next_o,
   output logic                         swap_o,
   output logic                         take_o
);
   import pq_ctrl_pkg::*;

   // Held key belongs before the stored one
   logic hold_lt;

   assign hold_lt = (hold_key_i < ram_key_i);

   always_comb begin
      ram_wr_key_o = '0;
      hold_next_o  = '0;
      swap_o       = 1'b0;
      take_o       = 1'b0;
      case (mode_i)
         ////////////////////////////////////////////////////////////
         // Enqueue
         ////////////////////////////////////////////////////////////
         VR_ENQ_CMP: begin
            swap_o = hold_lt;
            if (hold_lt) begin
               // Smaller key drops into RAM, larger one is carried on
               ram_wr_key_o = hold_key_i;
               hold_next_o  = ram_key_i;
            end else begin
               ram_wr_key_o = ram_key_i;
               hold_next_o  = hold_key_i;
            end
         end
         // Leftover key goes behind the last entry
         VR_ENQ_APPEND: begin
            ram_wr_key_o = hold_key_i;
            hold_next_o  = hold_key_i;
         end
         ////////////////////////////////////////////////////////////
         // Dequeue
         ////////////////////////////////////////////////////////////
         // Head key leaves through the holding register
         VR_DEQ_TAKE: begin
            take_o       = 1'b1;
            hold_next_o  = ram_key_i;
            ram_wr_key_o = ram_key_i;
         end
         // Entry i+1 moves up to i
         VR_DEQ_SHIFT: begin
            ram_wr_key_o = ram_key_i;
            hold_next_o  = hold_key_i;
         end
         default: ;
      endcase
   end

endmodule

// File: vlog.f
pq_cfg_pkg.sv
pq_ctrl_pkg.sv
pq_if.sv
value_router.sv
pq_engine.sv
pq_axil_front.sv
pq_result_collect.sv
pq_top.sv
tb_clk_gen.sv
tb_pq_top.sv
